// ==== src/dense_pkg.sv ====
package dense_pkg;

  // ======================================
  // Widths and defaults
  // ======================================
  localparam int DWIDTH    = 16;
  localparam int AWIDTH    = 40;
  localparam int BWIDTH    = 32;
  localparam int LWIDTH    = 16;
  localparam int MEMSIZE   = 10;
  localparam int NETSIZE   = 10;
  localparam int FRAC_BITS = 8;
  localparam int PADDR_W   = 14;

  typedef logic signed [DWIDTH-1:0] data_t;
  typedef logic signed [AWIDTH-1:0] acc_t;
  typedef logic [BWIDTH-1:0]        bus_t;
  typedef logic [LWIDTH-1:0]        len_t;
  typedef logic [PADDR_W-1:0]       paddr_t;

  // ======================================
  // Address map, byte offsets
  // ======================================
  localparam paddr_t REG_CTRL       = 'h000;
  localparam paddr_t REG_IN_OFFSET  = 'h004;
  localparam paddr_t REG_OUT_OFFSET = 'h008;
  localparam paddr_t REG_NET_OFFSET = 'h00C;
  localparam paddr_t REG_SIZE       = 'h010;
  localparam paddr_t REG_FLAGS      = 'h014;
  localparam paddr_t IMG_BASE       = 'h1000;
  localparam paddr_t NET_BASE       = 'h2000;

  typedef struct packed {
    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    bus_t   pwdata;
  } apb_req_t;

  typedef struct packed {
    bus_t prdata;
    logic pready;
    logic pslverr;
  } apb_rsp_t;

  typedef struct packed {
    len_t in_offset;
    len_t out_offset;
    len_t net_offset;
    len_t total_in;
    len_t total_out;
    logic bias_en;
    logic relu_en;
  } layer_cfg_t;

  typedef enum logic [2:0] {
    IDLE,
    BIAS,
    MAC,
    DRAIN,
    WRITE
  } core_state_t;

endpackage

// ==== src/word_ram.sv ====
`timescale 1ns/1ns

module word_ram import dense_pkg::*; #(
  parameter int ADDR_W = MEMSIZE
) (
  input  logic              clk,
  input  logic              a_we,
  input  logic [ADDR_W-1:0] a_addr,
  input  data_t             a_wdata,
  output data_t             a_rdata,
  input  logic              b_we,
  input  logic [ADDR_W-1:0] b_addr,
  input  data_t             b_wdata,
  output data_t             b_rdata
);

  data_t mem [2**ADDR_W];

  // Read returns the old word on a same-cycle write
  always_ff @(posedge clk) begin
    if (a_we) begin
      mem[a_addr] <= a_wdata;
    end
    if (b_we) begin
      mem[b_addr] <= b_wdata;
    end
    a_rdata <= mem[a_addr];
    b_rdata <= mem[b_addr];
  end

  // Host and core must never write one word together
  assert property (@(posedge clk) !(a_we && b_we && a_addr == b_addr))
    else $error("word_ram: both ports write address %0h", a_addr);

endmodule

// ==== src/dense_regs.sv ====
`timescale 1ns/1ns

module dense_regs import dense_pkg::*; #(
  parameter int MEM_AW = MEMSIZE,
  parameter int NET_AW = NETSIZE
) (
  input  logic              clk,
  input  logic              xrst,
  input  apb_req_t          apb_req,
  output apb_rsp_t          apb_rsp,
  output layer_cfg_t        cfg,
  output logic              start,
  input  logic              busy,
  output logic              img_we,
  output logic [MEM_AW-1:0] img_addr,
  output data_t             img_wdata,
  input  data_t             img_rdata,
  output logic              net_we,
  output logic [NET_AW-1:0] net_addr,
  output data_t             net_wdata,
  input  data_t             net_rdata
);

  localparam int RGN_W = PADDR_W - 12;
  localparam logic [RGN_W-1:0] IMG_RGN = IMG_BASE[PADDR_W-1:12];
  localparam logic [RGN_W-1:0] NET_RGN = NET_BASE[PADDR_W-1:12];

  logic [RGN_W-1:0] region;
  logic [RGN_W-1:0] src_q;
  logic             access;
  logic             wr;
  logic             mem_sel;
  logic             reject;
  logic             pready_q;
  logic             pslverr_q;
  logic             busy_q;
  logic             busy_fall;
  logic             done;
  bus_t             reg_rdata;
  bus_t             reg_rdata_q;
  bus_t             rsp_data;

  // ======================================
  // Decode
  // ======================================
  assign region  = apb_req.paddr[PADDR_W-1:12];
  // Only the first access cycle acts
  assign access  = apb_req.psel && apb_req.penable && !pready_q;
  assign wr      = access && apb_req.pwrite;
  assign mem_sel = region == IMG_RGN || region == NET_RGN;
  assign reject  = mem_sel && busy;

  assign img_addr  = apb_req.paddr[MEM_AW+1:2];
  assign net_addr  = apb_req.paddr[NET_AW+1:2];
  assign img_wdata = apb_req.pwdata[DWIDTH-1:0];
  assign net_wdata = apb_req.pwdata[DWIDTH-1:0];
  assign img_we    = wr && !busy && region == IMG_RGN;
  assign net_we    = wr && !busy && region == NET_RGN;

  // ======================================
  // Layer registers
  // ======================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      cfg <= '0;
    end else if (wr) begin
      case (apb_req.paddr)
        REG_IN_OFFSET:  cfg.in_offset  <= apb_req.pwdata[LWIDTH-1:0];
        REG_OUT_OFFSET: cfg.out_offset <= apb_req.pwdata[LWIDTH-1:0];
        REG_NET_OFFSET: cfg.net_offset <= apb_req.pwdata[LWIDTH-1:0];
        REG_SIZE: begin
          cfg.total_out <= apb_req.pwdata[2*LWIDTH-1:LWIDTH];
          cfg.total_in  <= apb_req.pwdata[LWIDTH-1:0];
        end
        REG_FLAGS: begin
          cfg.bias_en <= apb_req.pwdata[0];
          cfg.relu_en <= apb_req.pwdata[1];
        end
        default: ;
      endcase
    end
  end

  // Done already shows in the cycle busy falls
  assign busy_fall = busy_q && !busy;

  // Start pulse and done flag
  always_ff @(posedge clk) begin
    if (!xrst) begin
      start  <= 1'b0;
      busy_q <= 1'b0;
      done   <= 1'b0;
    end else begin
      start  <= wr && apb_req.paddr == REG_CTRL && apb_req.pwdata[0] && !busy;
      busy_q <= busy;
      if (start) begin
        done <= 1'b0;
      end else if (busy_fall) begin
        done <= 1'b1;
      end
    end
  end

  always_comb begin
    case (apb_req.paddr)
      REG_CTRL:       reg_rdata = bus_t'({done || busy_fall, busy});
      REG_IN_OFFSET:  reg_rdata = bus_t'(cfg.in_offset);
      REG_OUT_OFFSET: reg_rdata = bus_t'(cfg.out_offset);
      REG_NET_OFFSET: reg_rdata = bus_t'(cfg.net_offset);
      REG_SIZE:       reg_rdata = {cfg.total_out, cfg.total_in};
      REG_FLAGS:      reg_rdata = bus_t'({cfg.relu_en, cfg.bias_en});
      default:        reg_rdata = '0;
    endcase
  end

  // ======================================
  // Response
  // ======================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      pready_q  <= 1'b0;
      pslverr_q <= 1'b0;
      src_q     <= '0;
    end else begin
      pready_q  <= access;
      pslverr_q <= access && reject;
      if (access) begin
        src_q <= region;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      reg_rdata_q <= reg_rdata;
    end
  end

  // RAM words arrive in the response cycle
  always_comb begin
    case (src_q)
      IMG_RGN: rsp_data = {{(BWIDTH - DWIDTH){img_rdata[DWIDTH-1]}}, img_rdata};
      NET_RGN: rsp_data = {{(BWIDTH - DWIDTH){net_rdata[DWIDTH-1]}}, net_rdata};
      default: rsp_data = reg_rdata_q;
    endcase
    apb_rsp.prdata  = pslverr_q ? '0 : rsp_data;
    apb_rsp.pready  = pready_q;
    apb_rsp.pslverr = pslverr_q;
  end

  assert property (@(posedge clk) disable iff (!xrst)
    apb_rsp.pready |-> apb_req.psel && apb_req.penable)
    else $error("dense_regs: pready outside access phase");

endmodule

// ==== src/dense_core.sv ====
`timescale 1ns/1ns

module dense_core import dense_pkg::*; #(
  parameter int MEM_AW = MEMSIZE,
  parameter int NET_AW = NETSIZE,
  parameter int FRAC   = FRAC_BITS
) (
  input  logic              clk,
  input  logic              xrst,
  input  logic              start,
  input  layer_cfg_t        cfg,
  output logic              busy,
  output logic [MEM_AW-1:0] img_addr,
  input  data_t             img_rdata,
  output logic              img_we,
  output data_t             img_wdata,
  output logic [NET_AW-1:0] net_addr,
  input  data_t             net_rdata
);

  localparam acc_t SAT_HI = acc_t'(2 ** (DWIDTH - 1) - 1);
  localparam acc_t SAT_LO = -SAT_HI - 1;

  core_state_t       state;
  len_t              in_cnt;
  len_t              out_cnt;
  len_t              total_in_q;
  len_t              total_out_q;
  logic              bias_en_q;
  logic              relu_en_q;
  logic [MEM_AW-1:0] in_base;
  logic [MEM_AW-1:0] x_addr;
  logic [MEM_AW-1:0] y_addr;
  logic [NET_AW-1:0] w_addr;
  logic [NET_AW-1:0] b_addr;
  logic              last_in;
  logic              last_out;
  logic              bias_v;
  logic              mac_v;
  acc_t              acc;
  acc_t              acc_sh;
  data_t             result;

  assign last_in  = in_cnt == total_in_q - 1'b1;
  assign last_out = out_cnt == total_out_q - 1'b1;
  assign busy     = state != IDLE;

  // ========================================
  // Control
  // ========================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (start) state <= BIAS;
        BIAS:    state <= MAC;
        MAC:     if (last_in) state <= DRAIN;
        DRAIN:   state <= WRITE;
        WRITE:   state <= last_out ? IDLE : BIAS;
        default: state <= IDLE;
      endcase
    end
  end

  // Weights are row by row, biases follow the last row
  always_ff @(posedge clk) begin
    case (state)
      IDLE: begin
        if (start) begin
          total_in_q  <= cfg.total_in;
          total_out_q <= cfg.total_out;
          bias_en_q   <= cfg.bias_en;
          relu_en_q   <= cfg.relu_en;
          in_base     <= MEM_AW'(cfg.in_offset);
          y_addr      <= MEM_AW'(cfg.out_offset);
          w_addr      <= NET_AW'(cfg.net_offset);
          b_addr      <= NET_AW'(cfg.net_offset + cfg.total_out * cfg.total_in);
          out_cnt     <= '0;
        end
      end
      BIAS: begin
        in_cnt <= '0;
        x_addr <= in_base;
      end
      MAC: begin
        in_cnt <= in_cnt + 1'b1;
        x_addr <= x_addr + 1'b1;
        w_addr <= w_addr + 1'b1;
      end
      WRITE: begin
        out_cnt <= out_cnt + 1'b1;
        y_addr  <= y_addr + 1'b1;
        b_addr  <= b_addr + 1'b1;
      end
      default: ;
    endcase
  end

  assign net_addr  = (state == BIAS) ? b_addr : w_addr;
  assign img_addr  = (state == WRITE) ? y_addr : x_addr;
  assign img_we    = state == WRITE;
  assign img_wdata = result;

  // ========================================
  // Datapath
  // ========================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      bias_v <= 1'b0;
      mac_v  <= 1'b0;
    end else begin
      bias_v <= state == BIAS;
      mac_v  <= state == MAC;
    end
  end

  // Bias word lands in the first MAC cycle, products one cycle after issue
  always_ff @(posedge clk) begin
    if (bias_v) begin
      acc <= bias_en_q ? (acc_t'(net_rdata) <<< FRAC) : '0;
    end else if (mac_v) begin
      acc <= acc + acc_t'(net_rdata) * acc_t'(img_rdata);
    end
  end

  always_comb begin
    acc_sh = acc >>> FRAC;
    if (relu_en_q && acc_sh < 0) begin
      result = '0;
    end else if (acc_sh > SAT_HI) begin
      result = data_t'(SAT_HI);
    end else if (acc_sh < SAT_LO) begin
      result = data_t'(SAT_LO);
    end else begin
      result = data_t'(acc_sh);
    end
  end

  assert property (@(posedge clk) disable iff (!xrst) start |-> !busy)
    else $error("dense_core: start while busy");

  assert property (@(posedge clk) disable iff (!xrst) start |-> cfg.total_in != '0)
    else $error("dense_core: start with total_in of zero");

endmodule

// ==== src/dense_top.sv ====
`timescale 1ns/1ns

module dense_top import dense_pkg::*; #(
  parameter int MEM_AW = MEMSIZE,
  parameter int NET_AW = NETSIZE,
  parameter int FRAC   = FRAC_BITS
) (
  input  logic     clk,
  input  logic     xrst,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  layer_cfg_t        cfg;
  logic              start;
  logic              busy;

  // Host side, port A
  logic              host_img_we;
  logic [MEM_AW-1:0] host_img_addr;
  data_t             host_img_wdata;
  data_t             host_img_rdata;
  logic              host_net_we;
  logic [NET_AW-1:0] host_net_addr;
  data_t             host_net_wdata;
  data_t             host_net_rdata;

  // Core side, port B
  logic              core_img_we;
  logic [MEM_AW-1:0] core_img_addr;
  data_t             core_img_wdata;
  data_t             core_img_rdata;
  logic [NET_AW-1:0] core_net_addr;
  data_t             core_net_rdata;

  dense_regs #(
    .MEM_AW (MEM_AW),
    .NET_AW (NET_AW)
  ) regs (
    .clk       (clk),
    .xrst      (xrst),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .cfg       (cfg),
    .start     (start),
    .busy      (busy),
    .img_we    (host_img_we),
    .img_addr  (host_img_addr),
    .img_wdata (host_img_wdata),
    .img_rdata (host_img_rdata),
    .net_we    (host_net_we),
    .net_addr  (host_net_addr),
    .net_wdata (host_net_wdata),
    .net_rdata (host_net_rdata)
  );

  dense_core #(
    .MEM_AW (MEM_AW),
    .NET_AW (NET_AW),
    .FRAC   (FRAC)
  ) core (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .cfg       (cfg),
    .busy      (busy),
    .img_addr  (core_img_addr),
    .img_rdata (core_img_rdata),
    .img_we    (core_img_we),
    .img_wdata (core_img_wdata),
    .net_addr  (core_net_addr),
    .net_rdata (core_net_rdata)
  );

  // ======================================
  // Memories
  // ======================================
  word_ram #(
    .ADDR_W (MEM_AW)
  ) img_buf (
    .clk     (clk),
    .a_we    (host_img_we),
    .a_addr  (host_img_addr),
    .a_wdata (host_img_wdata),
    .a_rdata (host_img_rdata),
    .b_we    (core_img_we),
    .b_addr  (core_img_addr),
    .b_wdata (core_img_wdata),
    .b_rdata (core_img_rdata)
  );

  // Core only reads the network memory
  word_ram #(
    .ADDR_W (NET_AW)
  ) net_mem (
    .clk     (clk),
    .a_we    (host_net_we),
    .a_addr  (host_net_addr),
    .a_wdata (host_net_wdata),
    .a_rdata (host_net_rdata),
    .b_we    (1'b0),
    .b_addr  (core_net_addr),
    .b_wdata ('0),
    .b_rdata (core_net_rdata)
  );

endmodule

// ==== sim/tb_dense.sv ====
`timescale 1ns/1ns

module tb_dense import dense_pkg::*; ();

  localparam int SEED      = 14464;
  localparam int MEM_WORDS = 2 ** MEMSIZE;
  localparam int NET_WORDS = 2 ** NETSIZE;
  localparam int MAX_N     = 16;
  // Worst case per layer plus bus transfers of about 5 cycles each
  localparam int LAYER_CYC    = MAX_N * (MAX_N + 8);
  localparam int XFER_CYC     = 5;
  localparam int LAYER_XFERS  = MAX_N * MAX_N + 5 * MAX_N + 16;
  localparam int SETUP_XFERS  = 64;
  localparam int WATCHDOG_CYC =
    2 * (4 * (LAYER_CYC + XFER_CYC * LAYER_XFERS) + XFER_CYC * SETUP_XFERS);

  logic     clk;
  logic     xrst;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  data_t img_shadow [MEM_WORDS];
  data_t net_shadow [NET_WORDS];
  int    checks;
  int    errors;

  dense_top #(
    .MEM_AW (MEMSIZE),
    .NET_AW (NETSIZE),
    .FRAC   (FRAC_BITS)
  ) DUT (
    .clk     (clk),
    .xrst    (xrst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYC);
    $display("ERRORS FOUND");
    $finish;
  end

  // ========================================
  // Compare tasks
  // ========================================
  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bus(input string name, input bus_t got, input bus_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // ========================================
  // APB host
  // ========================================
  task automatic apb_xfer(input logic write, input paddr_t addr, input bus_t wdata,
                          output bus_t rdata, output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    // Sample the response away from the rising edge
    @(negedge clk);
    check_bit($sformatf("pready wait state 0x%h", addr), apb_rsp.pready, 1'b0);
    @(negedge clk);
    check_bit($sformatf("pready response 0x%h", addr), apb_rsp.pready, 1'b1);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic bus_write(input paddr_t addr, input bus_t data);
    bus_t rd;
    logic err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_bit($sformatf("pslverr write 0x%h", addr), err, 1'b0);
  endtask

  task automatic bus_read(input paddr_t addr, output bus_t data);
    logic err;
    apb_xfer(1'b0, addr, '0, data, err);
    check_bit($sformatf("pslverr read 0x%h", addr), err, 1'b0);
  endtask

  task automatic img_write(input int idx, input data_t v);
    bus_write(IMG_BASE + paddr_t'((idx % MEM_WORDS) * 4), bus_t'(v));
    img_shadow[idx % MEM_WORDS] = v;
  endtask

  task automatic net_write(input int idx, input data_t v);
    bus_write(NET_BASE + paddr_t'((idx % NET_WORDS) * 4), bus_t'(v));
    net_shadow[idx % NET_WORDS] = v;
  endtask

  task automatic reg_roundtrip(input string name, input paddr_t addr, input bus_t wdata,
                               input bus_t exp);
    bus_t rd;
    bus_write(addr, wdata);
    bus_read(addr, rd);
    check_bus({"prdata ", name}, rd, exp);
  endtask

  // ========================================
  // Reference model
  // ========================================
  function automatic data_t ref_output(input layer_cfg_t c, input int o);
    longint acc;
    longint sh;
    int     i;
    acc = 0;
    for (i = 0; i < c.total_in; i++) begin
      acc += longint'(net_shadow[(c.net_offset + o * c.total_in + i) % NET_WORDS]) *
             longint'(img_shadow[(c.in_offset + i) % MEM_WORDS]);
    end
    if (c.bias_en) begin
      acc += longint'(net_shadow[(c.net_offset + c.total_out * c.total_in + o) % NET_WORDS])
             <<< FRAC_BITS;
    end
    sh = acc >>> FRAC_BITS;
    if (sh > 32767) sh = 32767;
    if (sh < -32768) sh = -32768;
    if (c.relu_en && sh < 0) sh = 0;
    return data_t'(sh);
  endfunction

  function automatic int rand_between(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  function automatic layer_cfg_t random_cfg(input int in_lo, input int out_lo, input bit flags);
    layer_cfg_t c;
    c            = '0;
    c.in_offset  = len_t'(rand_between(0, 200));
    c.out_offset = len_t'(rand_between(512, 600));
    c.net_offset = len_t'(rand_between(0, 400));
    c.total_in   = len_t'(rand_between(in_lo, MAX_N));
    c.total_out  = len_t'(rand_between(out_lo, MAX_N));
    c.bias_en    = flags;
    c.relu_en    = flags;
    return c;
  endfunction

  // Large mode forces both saturation limits and small negative sums
  function automatic data_t weight_for(input bit big, input int o);
    if (!big) return data_t'(rand_between(-256, 256));
    if (o == 0) return 16'sh7fff;
    if (o == 1) return -16'sh8000;
    if (o == 2) return data_t'(rand_between(-8, -1));
    return data_t'(rand_between(-32768, 32767));
  endfunction

  task automatic load_layer(input layer_cfg_t c, input bit big);
    int i;
    int o;
    for (i = 0; i < c.total_in; i++) begin
      img_write(c.in_offset + i,
                big ? data_t'(rand_between(4096, 16383)) : data_t'(rand_between(-1024, 1024)));
    end
    for (o = 0; o < c.total_out; o++) begin
      for (i = 0; i < c.total_in; i++) begin
        net_write(c.net_offset + o * c.total_in + i, weight_for(big, o));
      end
      net_write(c.net_offset + c.total_out * c.total_in + o, data_t'(rand_between(-2048, 2048)));
    end
    bus_write(REG_IN_OFFSET, bus_t'(c.in_offset));
    bus_write(REG_OUT_OFFSET, bus_t'(c.out_offset));
    bus_write(REG_NET_OFFSET, bus_t'(c.net_offset));
    bus_write(REG_SIZE, {c.total_out, c.total_in});
    bus_write(REG_FLAGS, bus_t'({c.relu_en, c.bias_en}));
  endtask

  task automatic wait_idle();
    bus_t ctrl;
    do begin
      bus_read(REG_CTRL, ctrl);
    end while (ctrl[0]);
    check_bit("done", ctrl[1], 1'b1);
  endtask

  task automatic check_outputs(input layer_cfg_t c);
    bus_t rd;
    int   o;
    int   idx;
    for (o = 0; o < c.total_out; o++) begin
      idx = (c.out_offset + o) % MEM_WORDS;
      bus_read(IMG_BASE + paddr_t'(idx * 4), rd);
      check_data($sformatf("img word 0x%0h", idx), data_t'(rd[DWIDTH-1:0]), ref_output(c, o));
    end
  endtask

  task automatic end_test(input int num, input string title, input int err_before);
    if (errors == err_before) begin
      $display("Test %0d %s: pass", num, title);
    end else begin
      $display("Test %0d %s: fail, %0d errors", num, title, errors - err_before);
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    layer_cfg_t cfg;
    layer_cfg_t cfg2;
    bus_t       v;
    bus_t       rd;
    logic       err;
    int         idx;
    int         k;
    int         err_before;
    paddr_t     undef [4];

    xrst    = 1'b0;
    apb_req = '0;
    checks  = 0;
    errors  = 0;
    undef   = '{'h018, 'h0FC, 'h800, 'h3000};
    void'($urandom(SEED));
    repeat (5) @(posedge clk);
    xrst <= 1'b1;

    err_before = errors;
    bus_read(REG_CTRL, rd);
    check_bus("prdata CTRL", rd, '0);
    v = $urandom;
    reg_roundtrip("IN_OFFSET", REG_IN_OFFSET, v, {16'h0, v[15:0]});
    v = $urandom;
    reg_roundtrip("OUT_OFFSET", REG_OUT_OFFSET, v, {16'h0, v[15:0]});
    v = $urandom;
    reg_roundtrip("NET_OFFSET", REG_NET_OFFSET, v, {16'h0, v[15:0]});
    v = $urandom;
    reg_roundtrip("SIZE", REG_SIZE, v, v);
    v = $urandom;
    reg_roundtrip("FLAGS", REG_FLAGS, v, {30'h0, v[1:0]});
    foreach (undef[k]) begin
      bus_read(undef[k], rd);
      check_bus($sformatf("prdata 0x%h", undef[k]), rd, '0);
    end
    end_test(1, "register readback", err_before);

    err_before = errors;
    for (k = 0; k < 8; k++) begin
      // Even words carry a negative value
      v   = $urandom | ((k % 2 == 0) ? 32'h8000 : 32'h0);
      idx = rand_between(0, MEM_WORDS - 1);
      bus_write(IMG_BASE + paddr_t'(idx * 4), v);
      bus_read(IMG_BASE + paddr_t'(idx * 4), rd);
      check_bus($sformatf("prdata img 0x%0h", idx), rd, {{16{v[15]}}, v[15:0]});
      img_shadow[idx] = data_t'(v[15:0]);
      idx = rand_between(0, NET_WORDS - 1);
      bus_write(NET_BASE + paddr_t'(idx * 4), v);
      bus_read(NET_BASE + paddr_t'(idx * 4), rd);
      check_bus($sformatf("prdata net 0x%0h", idx), rd, {{16{v[15]}}, v[15:0]});
      net_shadow[idx] = data_t'(v[15:0]);
    end
    end_test(2, "memory readback", err_before);

    err_before = errors;
    cfg = random_cfg(1, 1, 1'b1);
    load_layer(cfg, 1'b0);
    bus_write(REG_CTRL, 32'h1);
    wait_idle();
    check_outputs(cfg);
    end_test(3, "layer with bias and relu", err_before);

    err_before = errors;
    cfg = random_cfg(1, 3, 1'b0);
    load_layer(cfg, 1'b1);
    bus_write(REG_CTRL, 32'h1);
    wait_idle();
    check_outputs(cfg);
    end_test(4, "layer with saturation", err_before);

    err_before = errors;
    cfg = random_cfg(8, 8, 1'b1);
    load_layer(cfg, 1'b0);
    bus_write(REG_CTRL, 32'h1);
    idx = cfg.in_offset % MEM_WORDS;
    apb_xfer(1'b1, IMG_BASE + paddr_t'(idx * 4), bus_t'(~img_shadow[idx]), rd, err);
    check_bit("pslverr busy write", err, 1'b1);
    apb_xfer(1'b0, NET_BASE + paddr_t'((cfg.net_offset % NET_WORDS) * 4), '0, rd, err);
    check_bit("pslverr busy read", err, 1'b1);
    check_bus("prdata busy read", rd, '0);
    wait_idle();
    bus_read(IMG_BASE + paddr_t'(idx * 4), rd);
    check_data($sformatf("img word 0x%0h", idx), data_t'(rd[DWIDTH-1:0]), img_shadow[idx]);
    check_outputs(cfg);
    end_test(5, "access while busy", err_before);

    err_before = errors;
    cfg2            = cfg;
    cfg2.out_offset = cfg.out_offset + 16'd256;
    bus_write(REG_OUT_OFFSET, bus_t'(cfg2.out_offset));
    bus_write(REG_CTRL, 32'h1);
    bus_read(REG_CTRL, rd);
    check_bit("busy", rd[0], 1'b1);
    check_bit("done", rd[1], 1'b0);
    wait_idle();
    check_outputs(cfg2);
    check_outputs(cfg);
    end_test(6, "second start", err_before);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
src/dense_pkg.sv
src/word_ram.sv
src/dense_regs.sv
src/dense_core.sv
src/dense_top.sv
sim/tb_dense.sv

// ==== Bender.yml ====
package:
  name: dense_layer

sources:
  # RTL in compile order
  - src/dense_pkg.sv
  - src/word_ram.sv
  - src/dense_regs.sv
  - src/dense_core.sv
  - src/dense_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/tb_dense.sv
